/* soc.f */
soc_pkg.sv
reset_seq.sv
bus_router.sv
dev_table.sv
gpio_port.sv
soc_top.sv
soc_checker.sv
soc_tb.sv

/* run.sh */
#!/usr/bin/env bash
# compiles the testbench with Verilator and runs it, the exit status is the result
set -e
cd "$(dirname "$0")"
verilator --binary --assert -Wno-fatal --top-module soc_tb -f soc.f -o soc_sim
./obj_dir/soc_sim

/* soc_tb.sv */
/*
 * Directed testbench for soc_top, acting as the single bus master.
 * Inputs change on the falling clock edge and outputs are sampled there too.
 * Stops at the first error, or after 2000 cycles if the DUT stalls.
 */
`timescale 1ns/1ns
`default_nettype none

module soc_tb;

	localparam int CLK_PERIOD = 20;
	localparam int TIMEOUT_CYCLES = 2000;
	localparam int SEED = 41990;
	// word addresses, one slot is 1024 words
	localparam logic [29:0] GPIO_BASE = 30'h400;
	localparam logic [29:0] BAD_BASE = 30'h1400;

	logic clk_4x_w;
	logic rst_p;
	soc_pkg::bus_req_t bus_req;
	soc_pkg::bus_rsp_t bus_rsp;
	logic [7:0] gp_in;
	logic [7:0] gp_out;
	logic sys_rst;
	logic pwroff;
	// expected GPIO output register
	logic [7:0] gp_exp;
	int cycles = 0;

	soc_top DUT (
		.clk_4x_w  (clk_4x_w),
		.rst_p     (rst_p),
		.bus_req_i (bus_req),
		.bus_rsp_o (bus_rsp),
		.gp_i      (gp_in),
		.gp_o      (gp_out),
		.sys_rst_o (sys_rst),
		.pwroff_o  (pwroff)
	);

	initial begin
		clk_4x_w = 1'b0;
		forever begin
			#(CLK_PERIOD / 2) clk_4x_w = ~clk_4x_w;
		end
	end

	task automatic fail_run(input string what);
		$display("%s", what);
		$display("Test FAILED");
		$fatal(1, "run stopped at the first error");
	endtask

	// all tests together need a few hundred cycles
	always @(posedge clk_4x_w) begin
		cycles <= cycles + 1;
		if (cycles == TIMEOUT_CYCLES) begin
			fail_run("timeout, the DUT stopped answering");
		end
	end

	task automatic check_val(input string name, input logic [31:0] got,
		input logic [31:0] exp);
		assert (got === exp) else begin
			fail_run($sformatf("ERROR %s got 0x%h expected 0x%h", name, got, exp));
		end
	endtask

	// holds the request until rdy shows on a falling edge, then drops op
	task automatic bus_xfer(input logic [1:0] op, input logic [29:0] addr,
		input logic [31:0] wdata, input logic [3:0] sel, output logic [31:0] rdata);
		@(negedge clk_4x_w);
		// no transfer completes here, so bit 0 shows only the register
		check_val("gp_o", {24'h0, gp_out}, {24'h0, gp_exp});
		bus_req.op = op;
		bus_req.addr = addr;
		bus_req.data = wdata;
		bus_req.sel = sel;
		@(negedge clk_4x_w);
		while (!bus_rsp.rdy) begin
			@(negedge clk_4x_w);
		end
		rdata = bus_rsp.data;
		bus_req.op = soc_pkg::OP_NOP;
	endtask

	task automatic bus_write(input logic [29:0] addr, input logic [31:0] wdata,
		input logic [3:0] sel);
		logic [31:0] old;
		bus_xfer(soc_pkg::OP_WR, addr, wdata, sel, old);
	endtask

	task automatic bus_read(input logic [29:0] addr, output logic [31:0] rdata);
		bus_xfer(soc_pkg::OP_RD, addr, 32'h0, 4'hF, rdata);
	endtask

	// drops rst_p and counts the hold window while a read waits on the bus
	task automatic release_reset();
		int n;
		n = 0;
		rst_p = 1'b0;
		bus_req.op = soc_pkg::OP_RD;
		bus_req.addr = '0;
		bus_req.sel = 4'hF;
		do begin
			@(negedge clk_4x_w);
			n++;
			assert (!bus_rsp.rdy) else fail_run("rdy came while sys_rst_o was high");
		end while (sys_rst);
		bus_req.op = soc_pkg::OP_NOP;
		check_val("sys_rst_o hold cycles", n, soc_pkg::RST_HOLD_CYCLES);
		check_val("pwroff_o", {31'h0, pwroff}, 32'h0);
	endtask

	// waits for a sys_rst_o pulse and returns its length in cycles
	task automatic wait_reset_pulse(output int len);
		int rise_n;
		rise_n = 0;
		len = 0;
		while (!sys_rst) begin
			@(negedge clk_4x_w);
			rise_n++;
			assert (rise_n < 8) else fail_run("sys_rst_o did not rise after a request");
		end
		while (sys_rst) begin
			@(negedge clk_4x_w);
			len++;
		end
	endtask

	task automatic test_reset_release();
		repeat (10) begin
			@(negedge clk_4x_w);
			assert (sys_rst) else fail_run("sys_rst_o was low while rst_p was high");
		end
		release_reset();
	endtask

	task automatic test_dev_table();
		logic [31:0] exp_tbl [10];
		logic [31:0] rd;
		exp_tbl[0] = soc_pkg::SOC_ID;
		exp_tbl[1] = soc_pkg::SLOT_COUNT;
		exp_tbl[2] = soc_pkg::DEV_ID_DEVTBL;
		exp_tbl[3] = soc_pkg::DEV_ID_GPIO;
		exp_tbl[4] = soc_pkg::DEV_ID_INVALID;
		exp_tbl[5] = soc_pkg::SLOT_MAPSZ;
		exp_tbl[6] = soc_pkg::SLOT_MAPSZ;
		exp_tbl[7] = soc_pkg::SLOT_MAPSZ;
		exp_tbl[8] = {29'h0, soc_pkg::DEV_USEINTR_INVALID, soc_pkg::DEV_USEINTR_GPIO,
			soc_pkg::DEV_USEINTR_DEVTBL};
		exp_tbl[9] = 32'h0;
		for (int i = 0; i < 10; i++) begin
			bus_read(30'(i), rd);
			check_val($sformatf("devtbl word %0d", i), rd, exp_tbl[i]);
		end
	endtask

	task automatic test_gpio();
		logic [31:0] rd;
		logic [7:0] pins;
		bus_write(GPIO_BASE, 32'h5A, 4'h1);
		gp_exp = 8'h5A;
		repeat (2) @(negedge clk_4x_w);
		check_val("gp_o", {24'h0, gp_out}, {24'h0, gp_exp});
		bus_read(GPIO_BASE, rd);
		check_val("gpio word 0", rd, {24'h0, gp_exp});
		// byte 0 disabled, the register keeps its value
		bus_write(GPIO_BASE, 32'hFF, 4'h2);
		bus_read(GPIO_BASE, rd);
		check_val("gpio word 0", rd, {24'h0, gp_exp});
		pins = 8'($urandom);
		@(negedge clk_4x_w);
		gp_in = pins;
		repeat (3) @(negedge clk_4x_w);
		bus_read(GPIO_BASE + 30'd1, rd);
		check_val("gpio word 1", rd, {24'h0, pins});
		bus_xfer(soc_pkg::OP_RW, GPIO_BASE, 32'hC3, 4'h1, rd);
		check_val("gpio swap old value", rd, {24'h0, gp_exp});
		gp_exp = 8'hC3;
		bus_read(GPIO_BASE, rd);
		check_val("gpio word 0", rd, {24'h0, gp_exp});
	endtask

	task automatic test_invalid_slot();
		logic [31:0] rd;
		bus_read(BAD_BASE, rd);
		check_val("slot 5 read", rd, 32'h0);
		bus_write(BAD_BASE, 32'hFFFF_FFFF, 4'hF);
		bus_read(30'h0, rd);
		check_val("devtbl word 0", rd, soc_pkg::SOC_ID);
		bus_read(GPIO_BASE, rd);
		check_val("gpio word 0", rd, {24'h0, gp_exp});
		check_val("sys_rst_o", {31'h0, sys_rst}, 32'h0);
	endtask

	task automatic test_warm_cold();
		logic [31:0] rd;
		int len;
		bus_write(GPIO_BASE, 32'h3C, 4'h1);
		gp_exp = 8'h3C;
		// rst1 alone is a warm reset
		bus_write(30'h0, 32'h2, 4'h1);
		wait_reset_pulse(len);
		assert (len >= soc_pkg::RST_HOLD_CYCLES) else fail_run("warm reset pulse too short");
		bus_read(GPIO_BASE, rd);
		check_val("gpio word 0 after warm reset", rd, {24'h0, gp_exp});
		bus_write(30'h0, 32'h3, 4'h1);
		gp_exp = 8'h00;
		wait_reset_pulse(len);
		assert (len >= soc_pkg::RST_HOLD_CYCLES) else fail_run("cold reset pulse too short");
		bus_read(GPIO_BASE, rd);
		check_val("gpio word 0 after cold reset", rd, 32'h0);
	endtask

	task automatic test_power_off();
		int n;
		bus_write(30'h0, 32'h1, 4'h1);
		n = 0;
		while (!pwroff) begin
			@(negedge clk_4x_w);
			n++;
			assert (n < 8) else fail_run("pwroff_o did not rise after the request");
		end
		repeat (50) begin
			@(negedge clk_4x_w);
			assert (pwroff && sys_rst) else fail_run("power off did not hold the reset");
		end
		rst_p = 1'b1;
		repeat (2) @(negedge clk_4x_w);
		release_reset();
	endtask

	initial begin
		rst_p = 1'b1;
		bus_req = '0;
		gp_in = '0;
		gp_exp = '0;
		void'($urandom(SEED));
		test_reset_release();
		test_dev_table();
		test_gpio();
		test_invalid_slot();
		test_warm_cold();
		test_power_off();
		$display("Test OK");
		$finish;
	end

endmodule

`default_nettype wire

/* soc_checker.sv */
/*
 * Bus and reset properties, bound into soc_top.
 * Sampled on clk_4x_w. The rdy property is off while rst_p is high.
 */
`timescale 1ns/1ns
`default_nettype none

module soc_checker (
	input logic clk_4x_w,
	input logic rst_p,
	input soc_pkg::bus_req_t bus_req_i,
	input soc_pkg::bus_rsp_t bus_rsp_i,
	input logic sys_rst_i,
	input logic pwroff_i
);

	// rdy answers a request sampled one cycle earlier
	rdy_after_req: assert property (@(posedge clk_4x_w) disable iff (rst_p)
		$rose(bus_rsp_i.rdy) |-> $past(bus_req_i.op != soc_pkg::OP_NOP))
		else $error("rdy rose without a pending request");

	pwroff_holds_rst: assert property (@(posedge clk_4x_w) pwroff_i |-> sys_rst_i)
		else $error("pwroff_o high while sys_rst_o is low");

	// power off only ends through rst_p
	pwroff_sticky: assert property (@(posedge clk_4x_w) $fell(pwroff_i) |-> $past(rst_p))
		else $error("pwroff_o cleared without rst_p");

endmodule

bind soc_top soc_checker u_soc_checker (
	.clk_4x_w  (clk_4x_w),
	.rst_p     (rst_p),
	.bus_req_i (bus_req_i),
	.bus_rsp_i (bus_rsp_o),
	.sys_rst_i (sys_rst_o),
	.pwroff_i  (pwroff_o)
);

`default_nettype wire

/* soc_top.sv */
/*
 * Board top without processor or memory. An external master drives the bus.
 * One clock domain, clk_4x_w. rst_p is synchronous and active high.
 * sys_rst_o and pwroff_o show the sequencer state for the board.
 */
`timescale 1ns/1ns
`default_nettype none

module soc_top (
	input  logic clk_4x_w,
	input  logic rst_p,
	input  soc_pkg::bus_req_t bus_req_i,
	output soc_pkg::bus_rsp_t bus_rsp_o,
	input  logic [soc_pkg::GPIO_COUNT-1:0] gp_i,
	output logic [soc_pkg::GPIO_COUNT-1:0] gp_o,
	output logic sys_rst_o,
	output logic pwroff_o
);

	soc_pkg::swrst_t swrst_w;
	logic sys_rst_w;
	logic cold_rst_w;
	soc_pkg::bus_req_t dev_req_w;
	logic devtbl_sel_w;
	logic gpio_sel_w;
	soc_pkg::bus_rsp_t devtbl_rsp_w;
	soc_pkg::bus_rsp_t gpio_rsp_w;
	logic xfer_done_w;

	reset_seq u_reset_seq (
		.clk_4x_w   (clk_4x_w),
		.rst_p      (rst_p),
		.swrst_i    (swrst_w),
		.sys_rst_o  (sys_rst_w),
		.cold_rst_o (cold_rst_w),
		.pwroff_o   (pwroff_o)
	);

	bus_router u_bus_router (
		.clk_4x_w     (clk_4x_w),
		.sys_rst_i    (sys_rst_w),
		.bus_req_i    (bus_req_i),
		.bus_rsp_o    (bus_rsp_o),
		.dev_req_o    (dev_req_w),
		.devtbl_sel_o (devtbl_sel_w),
		.gpio_sel_o   (gpio_sel_w),
		.devtbl_rsp_i (devtbl_rsp_w),
		.gpio_rsp_i   (gpio_rsp_w),
		.xfer_done_o  (xfer_done_w)
	);

	dev_table u_dev_table (
		.clk_4x_w  (clk_4x_w),
		.sys_rst_i (sys_rst_w),
		.dev_req_i (dev_req_w),
		.sel_i     (devtbl_sel_w),
		.rsp_o     (devtbl_rsp_w),
		.swrst_o   (swrst_w)
	);

	gpio_port u_gpio_port (
		.clk_4x_w    (clk_4x_w),
		.sys_rst_i   (sys_rst_w),
		.cold_rst_i  (cold_rst_w),
		.dev_req_i   (dev_req_w),
		.sel_i       (gpio_sel_w),
		.rsp_o       (gpio_rsp_w),
		.xfer_done_i (xfer_done_w),
		.gp_i        (gp_i),
		.gp_o        (gp_o)
	);

	assign sys_rst_o = sys_rst_w;

endmodule

`default_nettype wire

/* gpio_port.sv */
/*
 * GPIO slave with an activity indicator on output bit 0.
 * Word 0 is the output register, byte 0 only. Word 1 reads the synced inputs.
 * The output register clears on cold reset only and survives a warm reset.
 * gp_i passes through two flops, so reads lag the pins by two cycles.
 */
`timescale 1ns/1ns
`default_nettype none

module gpio_port (
	input  logic clk_4x_w,
	input  logic sys_rst_i,
	input  logic cold_rst_i,
	input  soc_pkg::bus_req_t dev_req_i,
	input  logic sel_i,
	output soc_pkg::bus_rsp_t rsp_o,
	input  logic xfer_done_i,
	input  logic [soc_pkg::GPIO_COUNT-1:0] gp_i,
	output logic [soc_pkg::GPIO_COUNT-1:0] gp_o
);

	int unsigned word_n;
	logic take_w;
	logic wr_w;
	logic pend_q;
	logic [soc_pkg::ARCH_BITS-1:0] rd_w;
	logic [soc_pkg::ARCH_BITS-1:0] data_q;
	logic [soc_pkg::GPIO_COUNT-1:0] out_q;
	logic [soc_pkg::GPIO_COUNT-1:0] sync1_q;
	logic [soc_pkg::GPIO_COUNT-1:0] sync2_q;
	logic [soc_pkg::ACTIVITY_DIM_BITS-1:0] dim_q;
	logic act_w;

	assign word_n = {{(32 - soc_pkg::SLOT_WORD_BITS){1'b0}},
		dev_req_i.addr[soc_pkg::SLOT_WORD_BITS-1:0]};
	assign take_w = sel_i && (dev_req_i.op != soc_pkg::OP_NOP) && !pend_q && !sys_rst_i;
	assign wr_w = (dev_req_i.op == soc_pkg::OP_WR) || (dev_req_i.op == soc_pkg::OP_RW);

	always_comb begin
		case (word_n)
			0: rd_w = {{(soc_pkg::ARCH_BITS - soc_pkg::GPIO_COUNT){1'b0}}, out_q};
			1: rd_w = {{(soc_pkg::ARCH_BITS - soc_pkg::GPIO_COUNT){1'b0}}, sync2_q};
			default: rd_w = '0;
		endcase
	end

	always_ff @(posedge clk_4x_w) begin
		if (sys_rst_i) begin
			pend_q <= 1'b0;
		end else begin
			pend_q <= take_w;
		end
	end

	// read data is captured before the write, so a swap returns the old value
	always_ff @(posedge clk_4x_w) begin
		if (take_w) begin
			data_q <= rd_w;
		end
		sync1_q <= gp_i;
		sync2_q <= sync1_q;
	end

	always_ff @(posedge clk_4x_w) begin
		if (cold_rst_i) begin
			out_q <= '0;
		end else if (take_w && wr_w && (word_n == 0) && dev_req_i.sel[0]) begin
			out_q <= dev_req_i.data[soc_pkg::GPIO_COUNT-1:0];
		end
	end

	// one pulse per completed transfer, then the dimmer holds off new pulses
	assign act_w = xfer_done_i && (dim_q == '0);

	always_ff @(posedge clk_4x_w) begin
		if (sys_rst_i) begin
			dim_q <= '0;
		end else if (act_w) begin
			dim_q <= '1;
		end else if (dim_q != '0) begin
			dim_q <= dim_q - 1'b1;
		end
	end

	assign rsp_o.data = data_q;
	assign rsp_o.rdy = pend_q;
	assign gp_o = out_q | {{(soc_pkg::GPIO_COUNT - 1){1'b0}}, act_w};

endmodule

`default_nettype wire

/* dev_table.sv */
/*
 * Read-only device table with the software reset request register.
 * Words 0..8 hold the SoC ID, slot count, slot IDs, map sizes and useintr bits.
 * Word 0 write, byte 0 enabled, loads the two reset request bits.
 * The request bits clear under sys_rst, so each request fires once.
 */
`timescale 1ns/1ns
`default_nettype none

module dev_table (
	input  logic clk_4x_w,
	input  logic sys_rst_i,
	input  soc_pkg::bus_req_t dev_req_i,
	input  logic sel_i,
	output soc_pkg::bus_rsp_t rsp_o,
	output soc_pkg::swrst_t swrst_o
);

	int unsigned word_n;
	logic [31:0] id_off_w;
	logic take_w;
	logic wr_w;
	logic pend_q;
	logic [soc_pkg::ARCH_BITS-1:0] rd_w;
	logic [soc_pkg::ARCH_BITS-1:0] data_q;
	logic [soc_pkg::SLOT_COUNT-1:0][soc_pkg::ARCH_BITS-1:0] id_w;
	logic [soc_pkg::SLOT_COUNT-1:0] useintr_w;
	soc_pkg::swrst_t swrst_q;

	assign word_n = {{(32 - soc_pkg::SLOT_WORD_BITS){1'b0}},
		dev_req_i.addr[soc_pkg::SLOT_WORD_BITS-1:0]};
	assign id_off_w = word_n - 2;

	assign take_w = sel_i && (dev_req_i.op != soc_pkg::OP_NOP) && !pend_q && !sys_rst_i;
	assign wr_w = (dev_req_i.op == soc_pkg::OP_WR) || (dev_req_i.op == soc_pkg::OP_RW);

	// per-slot entries, indexed by slot number
	always_comb begin
		id_w = '0;
		id_w[soc_pkg::SLOT_DEVTBL] = soc_pkg::DEV_ID_DEVTBL;
		id_w[soc_pkg::SLOT_GPIO] = soc_pkg::DEV_ID_GPIO;
		id_w[soc_pkg::SLOT_INVALID] = soc_pkg::DEV_ID_INVALID;
		useintr_w = '0;
		useintr_w[soc_pkg::SLOT_DEVTBL] = soc_pkg::DEV_USEINTR_DEVTBL;
		useintr_w[soc_pkg::SLOT_GPIO] = soc_pkg::DEV_USEINTR_GPIO;
		useintr_w[soc_pkg::SLOT_INVALID] = soc_pkg::DEV_USEINTR_INVALID;
	end

	always_comb begin
		rd_w = '0;
		if (word_n == 0) begin
			rd_w = soc_pkg::SOC_ID;
		end else if (word_n == 1) begin
			rd_w = soc_pkg::SLOT_COUNT;
		end else if (word_n < 2 + soc_pkg::SLOT_COUNT) begin
			rd_w = id_w[id_off_w[soc_pkg::SLOT_IDX_BITS-1:0]];
		end else if (word_n < 2 + 2 * soc_pkg::SLOT_COUNT) begin
			rd_w = soc_pkg::SLOT_MAPSZ;
		end else if (word_n == 2 + 2 * soc_pkg::SLOT_COUNT) begin
			rd_w = {{(soc_pkg::ARCH_BITS - soc_pkg::SLOT_COUNT){1'b0}}, useintr_w};
		end
	end

	always_ff @(posedge clk_4x_w) begin
		if (sys_rst_i) begin
			pend_q <= 1'b0;
			swrst_q <= '0;
		end else begin
			pend_q <= take_w;
			if (take_w && wr_w && (word_n == 0) && dev_req_i.sel[0]) begin
				swrst_q.rst0 <= dev_req_i.data[0];
				swrst_q.rst1 <= dev_req_i.data[1];
			end
		end
	end

	always_ff @(posedge clk_4x_w) begin
		if (take_w) begin
			data_q <= rd_w;
		end
	end

	assign rsp_o.data = data_q;
	assign rsp_o.rdy = pend_q;
	assign swrst_o = swrst_q;

endmodule

`default_nettype wire

/* bus_router.sv */
/*
 * Slot decoder for a single bus master.
 * Address bits above the 1024-word slot offset select the slave.
 * Unmapped slots go to a built-in default device that reads zero.
 * Only one transfer is in flight. The master holds op until rdy.
 */
`timescale 1ns/1ns
`default_nettype none

module bus_router (
	input  logic clk_4x_w,
	input  logic sys_rst_i,
	input  soc_pkg::bus_req_t bus_req_i,
	output soc_pkg::bus_rsp_t bus_rsp_o,
	output soc_pkg::bus_req_t dev_req_o,
	output logic devtbl_sel_o,
	output logic gpio_sel_o,
	input  soc_pkg::bus_rsp_t devtbl_rsp_i,
	input  soc_pkg::bus_rsp_t gpio_rsp_i,
	output logic xfer_done_o
);

	logic [soc_pkg::SLOT_NUM_BITS-1:0] slot_num_w;
	logic slot_hi_zero_w;
	logic slot_valid_w;
	logic [soc_pkg::SLOT_IDX_BITS-1:0] slot_w;
	logic [soc_pkg::SLOT_IDX_BITS-1:0] slot_q;
	logic take_w;
	logic pend_q;
	soc_pkg::bus_rsp_t rsp_w;

	assign slot_num_w = bus_req_i.addr[soc_pkg::ADDR_BITS-1:soc_pkg::SLOT_WORD_BITS];

	// real slots sit below SLOT_INVALID, everything else is the default device
	assign slot_hi_zero_w =
		(slot_num_w[soc_pkg::SLOT_NUM_BITS-1:soc_pkg::SLOT_IDX_BITS] == '0);
	assign slot_valid_w = slot_hi_zero_w &&
		(slot_num_w[soc_pkg::SLOT_IDX_BITS-1:0] < soc_pkg::SLOT_INVALID);
	assign slot_w = slot_valid_w ? slot_num_w[soc_pkg::SLOT_IDX_BITS-1:0] :
		soc_pkg::SLOT_INVALID;

	assign dev_req_o = bus_req_i;
	assign devtbl_sel_o = (slot_w == soc_pkg::SLOT_DEVTBL);
	assign gpio_sel_o = (slot_w == soc_pkg::SLOT_GPIO);

	// mirrors the slave pending flag so the response mux follows the sampled slot
	assign take_w = (bus_req_i.op != soc_pkg::OP_NOP) && !pend_q;

	always_ff @(posedge clk_4x_w) begin
		if (sys_rst_i) begin
			pend_q <= 1'b0;
			slot_q <= soc_pkg::SLOT_INVALID;
		end else begin
			pend_q <= take_w;
			if (take_w) begin
				slot_q <= slot_w;
			end
		end
	end

	always_comb begin
		case (slot_q)
			soc_pkg::SLOT_DEVTBL: rsp_w = devtbl_rsp_i;
			soc_pkg::SLOT_GPIO: rsp_w = gpio_rsp_i;
			default: begin
				// default device, acks one cycle after sampling with zero data
				rsp_w.data = '0;
				rsp_w.rdy = pend_q;
			end
		endcase
	end

	assign bus_rsp_o = rsp_w;
	assign xfer_done_o = rsp_w.rdy;

endmodule

`default_nettype wire

/* reset_seq.sv */
/*
 * System reset sequencer on clk_4x_w.
 * rst_p is synchronous. sys_rst_o holds for RST_HOLD_CYCLES after it drops.
 * Software requests: both bits cold, rst1 only warm, rst0 only power off.
 * Power off keeps sys_rst_o high until the next rst_p.
 */
`timescale 1ns/1ns
`default_nettype none

module reset_seq (
	input  logic clk_4x_w,
	input  logic rst_p,
	input  soc_pkg::swrst_t swrst_i,
	output logic sys_rst_o,
	output logic cold_rst_o,
	output logic pwroff_o
);

	logic sw_cold_w;
	logic sw_warm_w;
	logic sw_pwroff_w;
	logic [soc_pkg::RST_CNT_BITS-1:0] hold_cnt_q;
	logic [soc_pkg::RST_CNT_BITS-1:0] hold_cnt_d;
	logic cold_q;
	logic pwroff_q;

	assign sw_cold_w = swrst_i.rst0 && swrst_i.rst1;
	assign sw_warm_w = !swrst_i.rst0 && swrst_i.rst1;
	assign sw_pwroff_w = swrst_i.rst0 && !swrst_i.rst1;

	// any request restarts the hold window
	always_comb begin
		hold_cnt_d = hold_cnt_q;
		if (sw_cold_w || sw_warm_w || sw_pwroff_w) begin
			hold_cnt_d = soc_pkg::RST_HOLD_CYCLES[soc_pkg::RST_CNT_BITS-1:0];
		end else if (hold_cnt_q != '0) begin
			hold_cnt_d = hold_cnt_q - 1'b1;
		end
	end

	always_ff @(posedge clk_4x_w) begin
		if (rst_p) begin
			hold_cnt_q <= soc_pkg::RST_HOLD_CYCLES[soc_pkg::RST_CNT_BITS-1:0];
			cold_q <= 1'b1;
			pwroff_q <= 1'b0;
		end else begin
			hold_cnt_q <= hold_cnt_d;
			// cold stays up exactly as long as the hold window
			cold_q <= sw_cold_w || (cold_q && (hold_cnt_d != '0));
			if (sw_pwroff_w) begin
				pwroff_q <= 1'b1;
			end
		end
	end

	assign sys_rst_o = (hold_cnt_q != '0) || pwroff_q;
	assign cold_rst_o = cold_q;
	assign pwroff_o = pwroff_q;

endmodule

`default_nettype wire

/* soc_pkg.sv */
/*
 * Shared bus types and constants for the slot-decoded peripheral bus.
 * Addresses are word addresses. Each slot covers 4 KB, which is 1024 words.
 * Slot indices must stay in table order. SLOT_INVALID is the last slot.
 */
`default_nettype none

package soc_pkg;

	localparam int ARCH_BITS = 32;
	localparam int ADDR_BITS = 30;
	localparam int SEL_BITS = 4;
	localparam int SLOT_WORD_BITS = 10;
	localparam int SLOT_NUM_BITS = ADDR_BITS - SLOT_WORD_BITS;
	localparam int GPIO_COUNT = 8;

	// bus op codes
	localparam logic [1:0] OP_NOP = 2'd0;
	localparam logic [1:0] OP_WR = 2'd1;
	localparam logic [1:0] OP_RD = 2'd2;
	// swap, writes and returns the old value
	localparam logic [1:0] OP_RW = 2'd3;

	// slot map, the default device answers every slot past the last real one
	localparam int SLOT_COUNT = 3;
	localparam int SLOT_IDX_BITS = 2;
	localparam logic [SLOT_IDX_BITS-1:0] SLOT_DEVTBL = SLOT_IDX_BITS'(0);
	localparam logic [SLOT_IDX_BITS-1:0] SLOT_GPIO = SLOT_IDX_BITS'(1);
	localparam logic [SLOT_IDX_BITS-1:0] SLOT_INVALID = SLOT_IDX_BITS'(2);
	localparam int SLOT_MAPSZ = 'h1000;

	// device table contents
	localparam int SOC_ID = 4;
	localparam int DEV_ID_DEVTBL = 7;
	localparam int DEV_ID_GPIO = 6;
	localparam int DEV_ID_INVALID = 0;
	localparam logic DEV_USEINTR_DEVTBL = 1'b0;
	localparam logic DEV_USEINTR_GPIO = 1'b1;
	localparam logic DEV_USEINTR_INVALID = 1'b0;

	localparam int RST_HOLD_CYCLES = 16;
	localparam int RST_CNT_BITS = $clog2(RST_HOLD_CYCLES + 1);
	localparam int ACTIVITY_DIM_BITS = 1;

	typedef struct packed {
		logic [1:0] op;
		logic [ADDR_BITS-1:0] addr;
		logic [ARCH_BITS-1:0] data;
		logic [SEL_BITS-1:0] sel;
	} bus_req_t;

	typedef struct packed {
		logic [ARCH_BITS-1:0] data;
		logic rdy;
	} bus_rsp_t;

	// software reset request bits as written through the device table
	typedef struct packed {
		logic rst0;
		logic rst1;
	} swrst_t;

endpackage

`default_nettype wire
